/* all.f */
+incdir+design
design/attackPkg.sv
design/controlDecoder.sv
design/hitboxPlacer.sv
design/boxOverlap.sv
design/attackSequencer.sv
design/attackCoprocessor.sv
sim/clockGen.sv
sim/attackCoprocessorTb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

logFile=sim.log

if ! verilator --binary --timing --assert -f all.f --top-module attackCoprocessorTb \
	--Mdir obj_dir -o simv; then
	echo "Verilator build failed"
	exit 1
fi

obj_dir/simv > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: PASS" "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1

/* sim/attackCoprocessorTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "attack_params.svh"

module attackCoprocessorTb;

	localparam int longLength = `LONG_WINDUP + `LONG_ACTIVE;
	// Directed attacks plus the random mix, with margin
	localparam int cycleLimit = 200 * (longLength + 4) + 400;

	logic clock;
	logic rstN;
	attackPkg::controlWord controls;
	attackPkg::point char1Pos;
	attackPkg::point char1Size;
	attackPkg::point char2Pos;
	attackPkg::point char2Size;
	logic [10:0] attack;

	// Reference model
	attackPkg::attackKind modelKind = attackPkg::none;
	logic modelBusy = 1'b0;
	logic modelFacing = 1'b0;
	int modelAge = 0;
	logic [10:0] expAttack;
	int cycles = 0;
	logic [31:0] rng = 32'h02446353;

	clockGen clockGen0 (.clock(clock), .rstN(rstN));

	attackCoprocessor dut0 (
		.clock(clock),
		.rstN(rstN),
		.controls(controls),
		.char1Pos(char1Pos),
		.char1Size(char1Size),
		.char2Pos(char2Pos),
		.char2Size(char2Size),
		.attack(attack)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic attackPkg::attackKind decodeRequest(input attackPkg::controlWord cw);
		logic [2:0] sx;
		logic [2:0] sy;
		sx = cw.stickX[7:5];
		sy = cw.stickY[7:5];
		if (cw.smashLeft) return attackPkg::smashLeft;
		if (cw.smashRight) return attackPkg::smashRight;
		if (cw.smashUp) return attackPkg::smashUp;
		if (cw.smashDown) return attackPkg::smashDown;
		if (cw.buttonA) return attackPkg::jab;
		if (!cw.buttonB) return attackPkg::none;
		if (sx == 3'b000) return attackPkg::specialLeft;
		if (sx == 3'b111) return attackPkg::specialRight;
		if (sy == 3'b111) return attackPkg::specialUp;
		if (sy == 3'b000) return attackPkg::specialDown;
		return attackPkg::specialNeutral;
	endfunction

	// 0 left, 1 right, 2 up, 3 down
	function automatic int sideOf(input attackPkg::attackKind kind, input logic faceRight);
		case (kind)
			attackPkg::smashLeft, attackPkg::specialLeft: return 0;
			attackPkg::smashRight, attackPkg::specialRight: return 1;
			attackPkg::smashUp, attackPkg::specialUp: return 2;
			attackPkg::smashDown, attackPkg::specialDown: return 3;
			attackPkg::jab, attackPkg::specialNeutral: return faceRight ? 1 : 0;
			default: return -1;
		endcase
	endfunction

	function automatic int windupOf(input attackPkg::attackKind kind);
		return (kind == attackPkg::jab) ? `SHORT_WINDUP : `LONG_WINDUP;
	endfunction

	function automatic int activeOf(input attackPkg::attackKind kind);
		return (kind == attackPkg::jab) ? `SHORT_ACTIVE : `LONG_ACTIVE;
	endfunction

	function automatic attackPkg::box placeBox(input int side, input attackPkg::point pos,
			input attackPkg::point size);
		attackPkg::box b;
		b.size.x = size.x / 16'd2;
		b.size.y = size.y / 16'd2;
		case (side)
			0: b.corner = {pos.x - b.size.x, pos.y + b.size.y / 16'd2};
			1: b.corner = {pos.x + size.x, pos.y + b.size.y / 16'd2};
			2: b.corner = {pos.x + b.size.x / 16'd2, pos.y + size.y};
			default: b.corner = {pos.x + b.size.x / 16'd2, pos.y - b.size.y / 16'd2};
		endcase
		return b;
	endfunction

	function automatic logic overlaps(input attackPkg::box a, input attackPkg::box b);
		return int'(a.corner.x) < int'(b.corner.x) + int'(b.size.x)
			&& int'(b.corner.x) < int'(a.corner.x) + int'(a.size.x)
			&& int'(a.corner.y) < int'(b.corner.y) + int'(b.size.y)
			&& int'(b.corner.y) < int'(a.corner.y) + int'(a.size.y);
	endfunction

	function automatic attackPkg::controlWord packWord(input logic [3:0] smash,
			input logic [1:0] buttons, input logic [7:0] sx, input logic [7:0] sy,
			input logic faceRight);
		return {5'd0, faceRight, 2'd0, smash, 2'd0, buttons, sx, sy};
	endfunction

	// One word that asks for the given kind and nothing else
	function automatic attackPkg::controlWord wordFor(input attackPkg::attackKind kind,
			input logic faceRight);
		case (kind)
			attackPkg::smashLeft: return packWord(4'b1000, 2'b00, 8'h80, 8'h80, faceRight);
			attackPkg::smashRight: return packWord(4'b0100, 2'b00, 8'h80, 8'h80, faceRight);
			attackPkg::smashUp: return packWord(4'b0010, 2'b00, 8'h80, 8'h80, faceRight);
			attackPkg::smashDown: return packWord(4'b0001, 2'b00, 8'h80, 8'h80, faceRight);
			attackPkg::jab: return packWord(4'b0000, 2'b01, 8'h80, 8'h80, faceRight);
			attackPkg::specialLeft: return packWord(4'b0000, 2'b10, 8'h00, 8'h80, faceRight);
			attackPkg::specialRight: return packWord(4'b0000, 2'b10, 8'hFF, 8'h80, faceRight);
			attackPkg::specialUp: return packWord(4'b0000, 2'b10, 8'h80, 8'hFF, faceRight);
			attackPkg::specialDown: return packWord(4'b0000, 2'b10, 8'h80, 8'h00, faceRight);
			default: return packWord(4'b0000, 2'b10, 8'h80, 8'h80, faceRight);
		endcase
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic waitEdge();
		@(posedge clock);
		#1;
	endtask

	always @(posedge clock) begin
		if (!rstN) begin
			modelKind <= attackPkg::none;
			modelBusy <= 1'b0;
			modelAge <= 0;
		end else if (!modelBusy && decodeRequest(controls) != attackPkg::none) begin
			modelKind <= decodeRequest(controls);
			modelBusy <= 1'b1;
			modelFacing <= controls.facingRight;
			modelAge <= 0;
		end else if (modelBusy) begin
			modelAge <= modelAge + 1;
			if (modelAge + 1 == windupOf(modelKind) + activeOf(modelKind)) begin
				modelKind <= attackPkg::none;
				modelBusy <= 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			abortRun($sformatf("Timeout after %0d cycles, the tests did not finish", cycles));
		end
	end

	always_comb begin
		expAttack = '0;
		if (modelBusy && modelAge >= windupOf(modelKind)
				&& overlaps(placeBox(sideOf(modelKind, modelFacing), char1Pos, char1Size),
				{char2Pos, char2Size})) begin
			expAttack[int'(modelKind)] = 1'b1;
			expAttack[0] = 1'b1;
		end
	end

	attackFollowsModel: assert property (@(negedge clock) attack === expAttack)
		else abortRun($sformatf("ERROR attack expected %h actual %h", expAttack, attack));

	// Put character 2 in one box, hold a word, count hits until idle
	task automatic strike(input attackPkg::controlWord cw, input attackPkg::attackKind kind,
			input int targetSide, input int hold = 1, input int attacks = 1);
		attackPkg::box target;
		int hits;
		int expHits;
		target = placeBox(targetSide, char1Pos, char1Size);
		char2Pos = {target.corner.x + 16'd2, target.corner.y + 16'd2};
		expHits = (targetSide == sideOf(kind, cw.facingRight)) ? attacks * activeOf(kind) : 0;
		hits = 0;
		controls = cw;
		for (int i = 0; i < hold || modelBusy; i++) begin
			if (i == hold) begin
				controls = '0;
			end
			@(negedge clock);
			hits += int'(attack[int'(kind)]);
			waitEdge();
		end
		assert (hits == expHits)
			else abortRun($sformatf("ERROR hits on attack bit %0d expected %h actual %h",
				int'(kind), expHits, hits));
	endtask

	initial begin
		attackPkg::attackKind kind;
		attackPkg::controlWord cw;
		int side;
		controls = '0;
		char1Pos = {16'd1000, 16'd1000};
		char1Size = {16'd40, 16'd60};
		char2Pos = '0;
		char2Size = {16'd4, 16'd4};
		@(posedge rstN);
		assert (attack == 11'd0) else abortRun("Attack word is not clear right after reset");

		// Each kind alone, into its own box and then into another one
		for (int k = 1; k <= 10; k++) begin
			kind = attackPkg::attackKind'(k);
			cw = wordFor(kind, k[0]);
			side = sideOf(kind, cw.facingRight);
			strike(cw, kind, side);
			strike(cw, kind, (side + 1) % 4);
		end

		// Several inputs at once, sticks near the thresholds
		strike(packWord(4'b1111, 2'b11, 8'h00, 8'hFF, 1'b0), attackPkg::smashLeft, 0);
		strike(packWord(4'b0111, 2'b11, 8'hFF, 8'h00, 1'b0), attackPkg::smashRight, 1);
		strike(packWord(4'b0011, 2'b10, 8'h80, 8'h80, 1'b0), attackPkg::smashUp, 2);
		strike(packWord(4'b0001, 2'b01, 8'h00, 8'h00, 1'b0), attackPkg::smashDown, 3);
		strike(packWord(4'b0000, 2'b11, 8'h00, 8'hFF, 1'b1), attackPkg::jab, 1);
		strike(packWord(4'b0000, 2'b10, 8'h1F, 8'hE0, 1'b0), attackPkg::specialLeft, 0);
		strike(packWord(4'b0000, 2'b10, 8'hE0, 8'h00, 1'b0), attackPkg::specialRight, 1);
		strike(packWord(4'b0000, 2'b10, 8'h20, 8'hE0, 1'b0), attackPkg::specialUp, 2);
		strike(packWord(4'b0000, 2'b10, 8'hDF, 8'h1F, 1'b0), attackPkg::specialDown, 3);
		strike(packWord(4'b0000, 2'b10, 8'h20, 8'hDF, 1'b1), attackPkg::specialNeutral, 1);

		// Held request is ignored while busy, then restarts once
		strike(wordFor(attackPkg::smashUp, 1'b0), attackPkg::smashUp, 2, longLength + 4, 2);

		// Random words with positions that keep moving
		repeat (300) begin
			rng = xorshift(rng);
			controls = rng;
			if (rng[31:29] != 3'b000) begin
				{controls.smashLeft, controls.smashRight, controls.smashUp,
					controls.smashDown} = 4'b0000;
			end
			rng = xorshift(rng);
			char1Pos = {16'd1000 + {8'd0, rng[7:0]}, 16'd1000 + {8'd0, rng[15:8]}};
			char1Size = {16'd8 + {10'd0, rng[21:16]}, 16'd8 + {10'd0, rng[27:22]}};
			rng = xorshift(rng);
			char2Pos.x = char1Pos.x + {8'd0, rng[7:0]} - 16'd96;
			char2Pos.y = char1Pos.y + {8'd0, rng[15:8]} - 16'd96;
			char2Size = {16'd4 + {11'd0, rng[20:16]}, 16'd4 + {11'd0, rng[25:21]}};
			waitEdge();
		end
		controls = '0;
		while (modelBusy) waitEdge();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clock,
	output logic rstN
);

	localparam int halfPeriod = 20;
	localparam int resetCycles = 2;

	initial begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	// Released just after an edge, like the other inputs
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		#1 rstN = 1'b1;
	end

endmodule

`default_nettype wire

/* design/attackCoprocessor.sv */
`timescale 1ns/1ps
`default_nettype none

module attackCoprocessor (
	input wire logic clock,
	input wire logic rstN,
	input wire attackPkg::controlWord controls,
	input wire attackPkg::point char1Pos,
	input wire attackPkg::point char1Size,
	input wire attackPkg::point char2Pos,
	input wire attackPkg::point char2Size,
	output logic [10:0] attack
);

	attackPkg::attackKind request;
	logic facingRight;
	attackPkg::attackState state;
	logic facing;

	attackPkg::box leftBox;
	attackPkg::box rightBox;
	attackPkg::box upBox;
	attackPkg::box downBox;
	attackPkg::box char2Box;

	logic leftHit;
	logic rightHit;
	logic upHit;
	logic downHit;
	logic hit;
	logic [10:1] kindHits;

	controlDecoder decoder0 (
		.controls(controls),
		.request(request),
		.facingRight(facingRight)
	);

	attackSequencer sequencer0 (
		.clock(clock),
		.rstN(rstN),
		.request(request),
		.facingIn(facingRight),
		.state(state),
		.facing(facing)
	);

	hitboxPlacer placer0 (
		.pos(char1Pos),
		.size(char1Size),
		.leftBox(leftBox),
		.rightBox(rightBox),
		.upBox(upBox),
		.downBox(downBox)
	);

	assign char2Box = '{corner: char2Pos, size: char2Size};

	boxOverlap leftOverlap (.a(leftBox), .b(char2Box), .overlap(leftHit));
	boxOverlap rightOverlap (.a(rightBox), .b(char2Box), .overlap(rightHit));
	boxOverlap upOverlap (.a(upBox), .b(char2Box), .overlap(upHit));
	boxOverlap downOverlap (.a(downBox), .b(char2Box), .overlap(downHit));

	// Each attack checks its own box
	always_comb begin
		case (state.kind)
			attackPkg::smashLeft, attackPkg::specialLeft: hit = leftHit;
			attackPkg::smashRight, attackPkg::specialRight: hit = rightHit;
			attackPkg::smashUp, attackPkg::specialUp: hit = upHit;
			attackPkg::smashDown, attackPkg::specialDown: hit = downHit;
			// Side character 1 faced when the attack started
			attackPkg::jab, attackPkg::specialNeutral: hit = facing ? rightHit : leftHit;
			default: hit = 1'b0;
		endcase
	end

	always_comb begin
		for (int k = 1; k <= 10; k++) begin
			kindHits[k] = state.active && hit && (int'(state.kind) == k);
		end
	end

	assign attack = {kindHits, |kindHits};

endmodule

`default_nettype wire

/* design/attackSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "attack_params.svh"

module attackSequencer (
	input wire logic clock,
	input wire logic rstN,
	input wire attackPkg::attackKind request,
	input wire logic facingIn,
	output attackPkg::attackState state,
	output logic facing
);

	localparam int timerWidth = `TIMER_WIDTH;

	// Counter loads are one less than the phase length
	localparam logic [timerWidth-1:0] longWindupLoad = timerWidth'(`LONG_WINDUP - 1);
	localparam logic [timerWidth-1:0] longActiveLoad = timerWidth'(`LONG_ACTIVE - 1);
	localparam logic [timerWidth-1:0] shortWindupLoad = timerWidth'(`SHORT_WINDUP - 1);
	localparam logic [timerWidth-1:0] shortActiveLoad = timerWidth'(`SHORT_ACTIVE - 1);

	logic [timerWidth-1:0] count;
	logic [timerWidth-1:0] windupLoad;
	logic [timerWidth-1:0] activeLoad;
	logic accept;

	// Requests while busy are dropped
	assign accept = !state.busy && (request != attackPkg::none);

	// Jab is the only short attack
	assign windupLoad = (request == attackPkg::jab) ? shortWindupLoad : longWindupLoad;
	assign activeLoad = (state.kind == attackPkg::jab) ? shortActiveLoad : longActiveLoad;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state.kind <= attackPkg::none;
			state.busy <= 1'b0;
			state.active <= 1'b0;
			count <= '0;
		end else if (accept) begin
			state.kind <= request;
			state.busy <= 1'b1;
			state.active <= 1'b0;
			count <= windupLoad;
		end else if (state.busy) begin
			if (count != '0) begin
				count <= count - 1'b1;
			end else if (!state.active) begin
				// Wind-up done
				state.active <= 1'b1;
				count <= activeLoad;
			end else begin
				state.kind <= attackPkg::none;
				state.busy <= 1'b0;
				state.active <= 1'b0;
			end
		end
	end

	// Side faced when the attack was accepted
	always_ff @(posedge clock) begin
		if (!rstN) begin
			facing <= 1'b0;
		end else if (accept) begin
			facing <= facingIn;
		end
	end

endmodule

`default_nettype wire

/* design/boxOverlap.sv */
`timescale 1ns/1ps
`default_nettype none

`include "attack_params.svh"

module boxOverlap (
	input wire attackPkg::box a,
	input wire attackPkg::box b,
	output logic overlap
);

	// Far edges one bit wider so big boxes don't wrap
	logic [`COORD_WIDTH:0] aRight;
	logic [`COORD_WIDTH:0] aTop;
	logic [`COORD_WIDTH:0] bRight;
	logic [`COORD_WIDTH:0] bTop;

	assign aRight = {1'b0, a.corner.x} + {1'b0, a.size.x};
	assign aTop = {1'b0, a.corner.y} + {1'b0, a.size.y};
	assign bRight = {1'b0, b.corner.x} + {1'b0, b.size.x};
	assign bTop = {1'b0, b.corner.y} + {1'b0, b.size.y};

	// Touching edges do not count
	assign overlap = ({1'b0, a.corner.x} < bRight) && ({1'b0, b.corner.x} < aRight)
		&& ({1'b0, a.corner.y} < bTop) && ({1'b0, b.corner.y} < aTop);

endmodule

`default_nettype wire

/* design/hitboxPlacer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "attack_params.svh"

module hitboxPlacer (
	input wire attackPkg::point pos,
	input wire attackPkg::point size,
	output attackPkg::box leftBox,
	output attackPkg::box rightBox,
	output attackPkg::box upBox,
	output attackPkg::box downBox
);

	logic [`COORD_WIDTH-1:0] halfW;
	logic [`COORD_WIDTH-1:0] halfH;

	// Boxes are half the character size, truncated
	assign halfW = size.x >> 1;
	assign halfH = size.y >> 1;

	always_comb begin
		leftBox.size.x = halfW;
		leftBox.size.y = halfH;
		leftBox.corner.x = pos.x - halfW;
		leftBox.corner.y = pos.y + (halfH >> 1);

		rightBox.size.x = halfW;
		rightBox.size.y = halfH;
		rightBox.corner.x = pos.x + size.x;
		rightBox.corner.y = pos.y + (halfH >> 1);

		upBox.size.x = halfW;
		upBox.size.y = halfH;
		upBox.corner.x = pos.x + (halfW >> 1);
		upBox.corner.y = pos.y + size.y;

		// Vertical offset comes from the height
		downBox.size.x = halfW;
		downBox.size.y = halfH;
		downBox.corner.x = pos.x + (halfW >> 1);
		downBox.corner.y = pos.y - (halfH >> 1);
	end

endmodule

`default_nettype wire

/* design/controlDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
	input wire attackPkg::controlWord controls,
	output attackPkg::attackKind request,
	output logic facingRight
);

	logic tiltLeft;
	logic tiltRight;
	logic tiltUp;
	logic tiltDown;

	// Stick thresholds on the top three bits of each axis
	assign tiltLeft = controls.stickX[7:5] == 3'b000;
	assign tiltRight = controls.stickX[7:5] == 3'b111;
	assign tiltUp = controls.stickY[7:5] == 3'b111;
	assign tiltDown = controls.stickY[7:5] == 3'b000;

	assign facingRight = controls.facingRight;

	// Fixed priority gives at most one request per cycle
	always_comb begin
		if (controls.smashLeft) begin
			request = attackPkg::smashLeft;
		end else if (controls.smashRight) begin
			request = attackPkg::smashRight;
		end else if (controls.smashUp) begin
			request = attackPkg::smashUp;
		end else if (controls.smashDown) begin
			request = attackPkg::smashDown;
		end else if (controls.buttonA) begin
			request = attackPkg::jab;
		end else if (controls.buttonB) begin
			if (tiltLeft) begin
				request = attackPkg::specialLeft;
			end else if (tiltRight) begin
				request = attackPkg::specialRight;
			end else if (tiltUp) begin
				request = attackPkg::specialUp;
			end else if (tiltDown) begin
				request = attackPkg::specialDown;
			end else begin
				request = attackPkg::specialNeutral;
			end
		end else begin
			request = attackPkg::none;
		end
	end

endmodule

`default_nettype wire

/* design/attackPkg.sv */
`default_nettype none

`include "attack_params.svh"

package attackPkg;

	// Controller word as the game writes it
	typedef struct packed {
		logic [4:0] reserved0;
		logic facingRight;
		logic [1:0] reserved1;
		logic smashLeft;
		logic smashRight;
		logic smashUp;
		logic smashDown;
		logic [1:0] reserved2;
		logic buttonB;
		logic buttonA;
		logic [7:0] stickX;
		logic [7:0] stickY;
	} controlWord;

	// Position or size with x as width and y as height in a size
	typedef struct packed {
		logic [`COORD_WIDTH-1:0] x;
		logic [`COORD_WIDTH-1:0] y;
	} point;

	// Lower-left corner plus extent
	typedef struct packed {
		point corner;
		point size;
	} box;

	// Values match the attack word bit positions
	typedef enum logic [3:0] {
		none = 4'd0,
		smashUp = 4'd1,
		smashDown = 4'd2,
		smashLeft = 4'd3,
		smashRight = 4'd4,
		jab = 4'd5,
		specialUp = 4'd6,
		specialDown = 4'd7,
		specialLeft = 4'd8,
		specialRight = 4'd9,
		specialNeutral = 4'd10
	} attackKind;

	typedef struct packed {
		attackKind kind;
		logic busy;
		logic active;
	} attackState;

endpackage

`default_nettype wire

/* design/attack_params.svh */
`ifndef ATTACK_PARAMS_SVH
`define ATTACK_PARAMS_SVH

// Width of one coordinate in a position or size word
`define COORD_WIDTH 16

// Smash and special attacks
`define LONG_WINDUP 6
`define LONG_ACTIVE 8

// Jab
`define SHORT_WINDUP 2
`define SHORT_ACTIVE 4

// Sequencer counter must hold the largest phase length
`define TIMER_WIDTH 8

`endif
